/* build.f */
+incdir+hdl
hdl/align_pkg.sv
hdl/fetch_ctrl.sv
hdl/resp_fifo.sv
hdl/instr_aligner.sv
hdl/align_buffer.sv
verification/align_buffer_tb.sv

/* hdl/align_buffer.sv */
// Top of the alignment buffer between the word prefetcher and the instruction fetch stage
`include "align_cfg.svh"

module align_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  // Core control
  input  logic                   instr_req_i,
  input  logic                   branch_i,
  input  logic [`ALIGN_XLEN-1:0] branch_addr_i,
  output logic                   prefetch_busy_o,
  // Prefetcher request
  output logic                   fetch_valid_o,
  input  logic                   fetch_ready_i,
  output logic                   fetch_branch_o,
  output logic [`ALIGN_XLEN-1:0] fetch_branch_addr_o,
  // Prefetcher response
  input  logic                   resp_valid_i,
  input  align_pkg::fetch_resp_t resp_i,
  // Fetch stage
  output logic                   instr_valid_o,
  input  logic                   instr_ready_i,
  output align_pkg::fetch_resp_t instr_o,
  output logic [`ALIGN_XLEN-1:0] instr_addr_o
);

  // Response accepted for the current path
  logic                   resp_keep;
  // Current word fully consumed
  logic                   word_pop;
  // Buffer view for the aligner
  align_pkg::fetch_resp_t head, next;
  logic                   head_valid, next_valid;

  // Prefetcher restarts at the word holding the target
  assign fetch_branch_o      = branch_i;
  assign fetch_branch_addr_o = {branch_addr_i[`ALIGN_XLEN-1:2], 2'b00};

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  fetch_ctrl u_fetch_ctrl (
    .clk             (clk),
    .rst_n           (rst_n),
    .instr_req_i     (instr_req_i),
    .branch_i        (branch_i),
    .branch_addr_i   (branch_addr_i),
    .fetch_ready_i   (fetch_ready_i),
    .resp_valid_i    (resp_valid_i),
    .resp_i          (resp_i),
    .instr_valid_i   (instr_valid_o),
    .instr_ready_i   (instr_ready_i),
    .fetch_valid_o   (fetch_valid_o),
    .prefetch_busy_o (prefetch_busy_o),
    .resp_keep_o     (resp_keep)
  );

  // Flushed on every branch
  resp_fifo u_resp_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_i       (resp_keep),
    .push_data_i  (resp_i),
    .pop_i        (word_pop),
    .clear_i      (branch_i),
    .head_o       (head),
    .next_o       (next),
    .head_valid_o (head_valid),
    .next_valid_o (next_valid)
  );

  instr_aligner u_instr_aligner (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .resp_keep_i   (resp_keep),
    .resp_i        (resp_i),
    .head_i        (head),
    .next_i        (next),
    .head_valid_i  (head_valid),
    .next_valid_i  (next_valid),
    .instr_ready_i (instr_ready_i),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o),
    .instr_addr_o  (instr_addr_o),
    .word_pop_o    (word_pop)
  );

endmodule

/* hdl/align_cfg.svh */
// Sizing macros for the alignment buffer, included by the package and every RTL file
`ifndef ALIGN_CFG_SVH
`define ALIGN_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Buffer sizing
//////////////////////////////////////////////////////////////////////

// Response words held between prefetcher and aligner
// Three is the least that lets a straddling instruction wait for its tail
`define ALIGN_FIFO_DEPTH 3

// Fetch requests allowed in flight towards the prefetcher
`define ALIGN_MAX_OUTSTANDING 2

// Width of a fetched word and of every address
`define ALIGN_XLEN 32

`endif

/* hdl/align_pkg.sv */
// Shared types of the alignment buffer, referenced by scoped name from RTL and testbench
`include "align_cfg.svh"

package align_pkg;

  //////////////////////////////////////////////////////////////////////
  // Response payload
  //////////////////////////////////////////////////////////////////////

  // One fetched word and its bus error flag
  // Also the shape of an instruction handed to the fetch stage
  typedef struct packed {
    logic [`ALIGN_XLEN-1:0] rdata;
    logic                   err;
  } fetch_resp_t;

  //////////////////////////////////////////////////////////////////////
  // Pointers and counters
  //////////////////////////////////////////////////////////////////////

  // Read and write index into the response buffer
  typedef logic [$clog2(`ALIGN_FIFO_DEPTH)-1:0] fifo_ptr_t;

  // Outstanding requests and responses still to be dropped
  typedef logic [$clog2(`ALIGN_MAX_OUTSTANDING+1)-1:0] txn_cnt_t;

  // Complete instructions in the buffer
  // Up to two compressed ones per word
  typedef logic [$clog2(2*`ALIGN_FIFO_DEPTH+1)-1:0] instr_cnt_t;

endpackage

/* hdl/fetch_ctrl.sv */
// Fetch request control with outstanding, flush and instruction counters for the aligner
`include "align_cfg.svh"

module fetch_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  // Core and branch control
  input  logic                   instr_req_i,
  input  logic                   branch_i,
  input  logic [`ALIGN_XLEN-1:0] branch_addr_i,
  // Prefetcher side
  input  logic                   fetch_ready_i,
  input  logic                   resp_valid_i,
  input  align_pkg::fetch_resp_t resp_i,
  // Fetch stage handshake
  input  logic                   instr_valid_i,
  input  logic                   instr_ready_i,
  output logic                   fetch_valid_o,
  output logic                   prefetch_busy_o,
  output logic                   resp_keep_o
);

  // Requests in flight and stale responses still owed
  align_pkg::txn_cnt_t   outstanding_cnt_q, outstanding_cnt_n;
  align_pkg::txn_cnt_t   flush_cnt_q, flush_cnt_n, flush_on_branch;
  // Buffered complete instructions
  align_pkg::instr_cnt_t instr_cnt_q, instr_cnt_n, instr_avail;
  // Complete instructions carried by the kept response
  logic [1:0]            n_incoming;
  // Write side position, aligned and complete
  logic                  aligned_q, aligned_n;
  logic                  complete_q, complete_n;
  // Emission seen last cycle
  logic                  pop_q;
  logic                  fetch_fire;
  logic                  lo_uncompressed, hi_uncompressed;

  //////////////////////////////////////////////////////////////////////
  // Request decision
  //////////////////////////////////////////////////////////////////////

  // Responses owed to the old path are dropped here
  assign resp_keep_o = resp_valid_i && (flush_cnt_q == '0);

  // Count corrected by last cycle's emission
  assign instr_avail = instr_cnt_q - align_pkg::instr_cnt_t'(pop_q);

  // Fetch on a branch, when empty, or when nearly empty and idle
  assign fetch_valid_o = instr_req_i &&
                         (outstanding_cnt_q < align_pkg::txn_cnt_t'(`ALIGN_MAX_OUTSTANDING)) &&
                         (branch_i ||
                          (instr_avail == '0) ||
                          ((instr_avail == align_pkg::instr_cnt_t'(1)) &&
                           (outstanding_cnt_q == '0)));

  // Busy while anything is owed or being asked for
  assign prefetch_busy_o = (outstanding_cnt_q != '0) || fetch_valid_o;

  assign fetch_fire = fetch_valid_o && fetch_ready_i;

  //////////////////////////////////////////////////////////////////////
  // Outstanding and flush counters
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    outstanding_cnt_n = outstanding_cnt_q;
    // Every response counts down, kept or not
    if (fetch_fire && !resp_valid_i) begin
      outstanding_cnt_n = outstanding_cnt_q + align_pkg::txn_cnt_t'(1);
    end else if (!fetch_fire && resp_valid_i) begin
      outstanding_cnt_n = outstanding_cnt_q - align_pkg::txn_cnt_t'(1);
    end
  end

  // A response in the branch cycle is already lost, so one fewer to drop
  assign flush_on_branch = outstanding_cnt_q - align_pkg::txn_cnt_t'(resp_valid_i);

  always_comb begin
    flush_cnt_n = flush_cnt_q;
    if (branch_i) begin
      flush_cnt_n = flush_on_branch;
    end else if (resp_valid_i && (flush_cnt_q != '0)) begin
      flush_cnt_n = flush_cnt_q - align_pkg::txn_cnt_t'(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Instruction counting on the write side
  //////////////////////////////////////////////////////////////////////

  assign lo_uncompressed = (resp_i.rdata[1:0] == 2'b11);
  assign hi_uncompressed = (resp_i.rdata[17:16] == 2'b11);

  always_comb begin
    aligned_n  = aligned_q;
    complete_n = complete_q;
    n_incoming = 2'd0;
    if (branch_i) begin
      // Unaligned target marks its lower half as skipped
      aligned_n  = !branch_addr_i[1];
      complete_n = branch_addr_i[1];
    end else if (resp_keep_o) begin
      if (aligned_q && lo_uncompressed) begin
        // Whole word is one instruction, position unchanged
        n_incoming = 2'd1;
      end else if (aligned_q || !complete_q) begin
        // Lower half ends an instruction
        // Either a compressed one or the tail of a straddler
        if (hi_uncompressed) begin
          n_incoming = 2'd1;
          aligned_n  = 1'b0;
          complete_n = 1'b0;
        end else begin
          n_incoming = 2'd2;
          aligned_n  = 1'b1;
          complete_n = 1'b1;
        end
      end else begin
        // First word after an unaligned branch
        if (hi_uncompressed) begin
          aligned_n  = 1'b0;
          complete_n = 1'b0;
        end else begin
          n_incoming = 2'd1;
          aligned_n  = 1'b1;
          complete_n = 1'b1;
        end
      end
    end
  end

  // Emissions are subtracted one cycle late
  always_comb begin
    if (branch_i) begin
      instr_cnt_n = '0;
    end else begin
      instr_cnt_n = instr_cnt_q + align_pkg::instr_cnt_t'(n_incoming) -
                    align_pkg::instr_cnt_t'(pop_q);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_cnt_q <= '0;
      flush_cnt_q       <= '0;
      instr_cnt_q       <= '0;
      aligned_q         <= 1'b1;
      complete_q        <= 1'b1;
      pop_q             <= 1'b0;
    end else begin
      outstanding_cnt_q <= outstanding_cnt_n;
      flush_cnt_q       <= flush_cnt_n;
      instr_cnt_q       <= instr_cnt_n;
      aligned_q         <= aligned_n;
      complete_q        <= complete_n;
      pop_q             <= instr_valid_i && instr_ready_i;
    end
  end

endmodule

/* hdl/instr_aligner.sv */
// Instruction extraction from buffered words, tracks the current PC and pops used words
`include "align_cfg.svh"

module instr_aligner (
  input  logic                   clk,
  input  logic                   rst_n,
  // Branch target load
  input  logic                   branch_i,
  input  logic [`ALIGN_XLEN-1:0] branch_addr_i,
  // Response arriving this cycle
  input  logic                   resp_keep_i,
  input  align_pkg::fetch_resp_t resp_i,
  // Buffer view
  input  align_pkg::fetch_resp_t head_i,
  input  align_pkg::fetch_resp_t next_i,
  input  logic                   head_valid_i,
  input  logic                   next_valid_i,
  // Fetch stage handshake
  input  logic                   instr_ready_i,
  output logic                   instr_valid_o,
  output align_pkg::fetch_resp_t instr_o,
  output logic [`ALIGN_XLEN-1:0] instr_addr_o,
  output logic                   word_pop_o
);

  // Byte distance between words
  localparam logic [`ALIGN_XLEN-1:0] word_step = 'd4;

  logic [`ALIGN_XLEN-1:0] addr_q, addr_n, addr_incr;
  // Word holding the PC, and the word after it
  align_pkg::fetch_resp_t src_lo, src_hi;
  logic                   any_valid, pair_valid;
  logic                   aligned_is_compressed, unaligned_is_compressed;
  logic                   err_unaligned;
  logic                   emit;

  //////////////////////////////////////////////////////////////////////
  // Source selection
  //////////////////////////////////////////////////////////////////////

  // Buffer first, else the response on the bus
  assign src_lo = head_valid_i ? head_i : resp_i;
  assign src_hi = next_valid_i ? next_i : resp_i;

  // One word available
  assign any_valid  = head_valid_i || resp_keep_i;
  // Two words available, head is implied by next
  assign pair_valid = next_valid_i || (head_valid_i && resp_keep_i);

  assign aligned_is_compressed   = (src_lo.rdata[1:0] != 2'b11);
  assign unaligned_is_compressed = (src_lo.rdata[17:16] != 2'b11);

  // Straddling instruction takes errors from both words
  assign err_unaligned = unaligned_is_compressed ? src_lo.err :
                                                   (src_lo.err || src_hi.err);

  //////////////////////////////////////////////////////////////////////
  // Output
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    instr_o       = src_lo;
    instr_valid_o = 1'b0;
    if (branch_i) begin
      // Old path is dead this cycle
      instr_valid_o = 1'b0;
    end else if (addr_q[1]) begin
      // Upper half of this word, lower half of the next
      instr_o.rdata = {src_hi.rdata[15:0], src_lo.rdata[31:16]};
      instr_o.err   = err_unaligned;
      instr_valid_o = unaligned_is_compressed ? any_valid : pair_valid;
    end else begin
      instr_valid_o = any_valid;
    end
  end

  assign emit = instr_valid_o && instr_ready_i;

  // Word is done after a full aligned one or anything unaligned
  assign word_pop_o = emit && (addr_q[1] || !aligned_is_compressed);

  //////////////////////////////////////////////////////////////////////
  // Program counter
  //////////////////////////////////////////////////////////////////////

  assign addr_incr = {addr_q[`ALIGN_XLEN-1:2], 2'b00} + word_step;

  always_comb begin
    addr_n = addr_q;
    if (addr_q[1]) begin
      // Straddler lands mid word, compressed lands on the boundary
      if (unaligned_is_compressed) begin
        addr_n = {addr_incr[`ALIGN_XLEN-1:2], 2'b00};
      end else begin
        addr_n = {addr_incr[`ALIGN_XLEN-1:2], 2'b10};
      end
    end else begin
      if (aligned_is_compressed) begin
        addr_n = {addr_q[`ALIGN_XLEN-1:2], 2'b10};
      end else begin
        addr_n = addr_incr;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addr_q <= '0;
    end else if (branch_i) begin
      // First instruction after the branch sits here
      addr_q <= branch_addr_i;
    end else if (emit) begin
      addr_q <= addr_n;
    end
  end

  assign instr_addr_o = addr_q;

endmodule

/* hdl/resp_fifo.sv */
// Three-entry response buffer that shows its head and the entry after it to the aligner
`include "align_cfg.svh"

module resp_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  // Write side, kept responses only
  input  logic                   push_i,
  input  align_pkg::fetch_resp_t push_data_i,
  // Read side, one word per pop
  input  logic                   pop_i,
  // Branch flush
  input  logic                   clear_i,
  output align_pkg::fetch_resp_t head_o,
  output align_pkg::fetch_resp_t next_o,
  output logic                   head_valid_o,
  output logic                   next_valid_o
);

  // Storage and per-entry valid bits
  align_pkg::fetch_resp_t         mem_q [`ALIGN_FIFO_DEPTH];
  logic [`ALIGN_FIFO_DEPTH-1:0]   valid_q, valid_n;
  align_pkg::fifo_ptr_t           rptr_q, wptr_q;
  align_pkg::fifo_ptr_t           rptr_nxt, wptr_nxt;

  // Step a pointer, wrapping at the last entry
  function automatic align_pkg::fifo_ptr_t ptr_inc(input align_pkg::fifo_ptr_t ptr);
    if (ptr == align_pkg::fifo_ptr_t'(`ALIGN_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + align_pkg::fifo_ptr_t'(1);
  endfunction

  assign rptr_nxt = ptr_inc(rptr_q);
  assign wptr_nxt = ptr_inc(wptr_q);

  //////////////////////////////////////////////////////////////////////
  // Read view
  //////////////////////////////////////////////////////////////////////

  assign head_o       = mem_q[rptr_q];
  assign next_o       = mem_q[rptr_nxt];
  assign head_valid_o = valid_q[rptr_q];
  assign next_valid_o = valid_q[rptr_nxt];

  // Pop wins when a word is used in the cycle it lands
  always_comb begin
    valid_n = valid_q;
    if (push_i) begin
      valid_n[wptr_q] = 1'b1;
    end
    if (pop_i) begin
      valid_n[rptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
      rptr_q  <= '0;
      wptr_q  <= '0;
    end else if (clear_i) begin
      // Start over empty from entry zero
      valid_q <= '0;
      rptr_q  <= '0;
      wptr_q  <= '0;
    end else begin
      valid_q <= valid_n;
      if (push_i) begin
        wptr_q <= wptr_nxt;
      end
      if (pop_i) begin
        rptr_q <= rptr_nxt;
      end
    end
  end

  // Payload words
  always_ff @(posedge clk) begin
    if (push_i && !clear_i) begin
      mem_q[wptr_q] <= push_data_i;
    end
  end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the alignment buffer testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -f build.f \
  --top-module align_buffer_tb -Mdir obj_dir -o align_buffer_sim \
  || { echo "build failed"; exit 1; }
out="$(./obj_dir/align_buffer_sim 2>&1)"
echo "$out"
grep -qx "test passed" <<< "$out" \
  && echo "simulation result: pass" \
  || { echo "simulation result: fail"; exit 1; }

/* verification/align_buffer_tb.sv */
// Testbench for the alignment buffer, with a prefetcher model, a reference walk and a checker
`include "align_cfg.svh"

module align_buffer_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS  = 256;
  localparam int WAIT_LIMIT = 2000;

  // DUT inputs
  logic                   clk = 1'b0;
  logic                   rst_n = 1'b0;
  logic                   instr_req_i = 1'b0;
  logic                   branch_i = 1'b0;
  logic [`ALIGN_XLEN-1:0] branch_addr_i = '0;
  logic                   fetch_ready_i = 1'b0;
  logic                   resp_valid_i = 1'b0;
  align_pkg::fetch_resp_t resp_i = '0;
  logic                   instr_ready_i = 1'b0;
  // DUT outputs
  logic                   fetch_valid_o;
  logic                   fetch_branch_o;
  logic [`ALIGN_XLEN-1:0] fetch_branch_addr_o;
  logic                   prefetch_busy_o;
  logic                   instr_valid_o;
  align_pkg::fetch_resp_t instr_o;
  logic [`ALIGN_XLEN-1:0] instr_addr_o;

  // Program memory with one error flag per word
  logic [`ALIGN_XLEN-1:0] mem [MEM_WORDS];
  logic                   err_mem [MEM_WORDS];

  // Scenario commands applied at the next rising edge
  logic                   rst_cmd = 1'b0;
  logic                   req_cmd = 1'b0;
  logic                   br_cmd = 1'b0;
  logic [`ALIGN_XLEN-1:0] br_addr_cmd = '0;
  logic                   bp_on = 1'b0;

  // Prefetcher model state
  logic [`ALIGN_XLEN-1:0] pf_addr = '0;
  logic [`ALIGN_XLEN-1:0] pend_addr [$];
  int                     pend_due [$];
  int                     cycle = 0;
  int                     n_fire = 0;
  int                     n_resp = 0;

  // Checker state
  logic [`ALIGN_XLEN-1:0] exp_pc = '0;
  int                     emit_cnt = 0;

  always #50 clk = ~clk;

  align_buffer dut_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .instr_req_i         (instr_req_i),
    .branch_i            (branch_i),
    .branch_addr_i       (branch_addr_i),
    .prefetch_busy_o     (prefetch_busy_o),
    .fetch_valid_o       (fetch_valid_o),
    .fetch_ready_i       (fetch_ready_i),
    .fetch_branch_o      (fetch_branch_o),
    .fetch_branch_addr_o (fetch_branch_addr_o),
    .resp_valid_i        (resp_valid_i),
    .resp_i              (resp_i),
    .instr_valid_o       (instr_valid_o),
    .instr_ready_i       (instr_ready_i),
    .instr_o             (instr_o),
    .instr_addr_o        (instr_addr_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Low bits of a halfword that start a 32-bit instruction about half the time
  function automatic logic [1:0] start_bits();
    if ($urandom % 2 == 0) begin
      return 2'b11;
    end
    return 2'($urandom % 3);
  endfunction

  // Expected instruction at pc and the address of the one after it
  function automatic logic [`ALIGN_XLEN-1:0] expect_instr(
    input  logic [`ALIGN_XLEN-1:0] pc,
    output align_pkg::fetch_resp_t want
  );
    logic [7:0]  w;
    logic [15:0] lo_half;
    logic [15:0] hi_half;
    w = pc[9:2];
    if (!pc[1]) begin
      lo_half  = mem[w][15:0];
      hi_half  = mem[w][31:16];
      want.err = err_mem[w];
    end else begin
      lo_half = mem[w][31:16];
      hi_half = mem[w + 8'd1][15:0];
      // Unaligned compressed stays inside its own word
      want.err = err_mem[w] || ((lo_half[1:0] == 2'b11) && err_mem[w + 8'd1]);
    end
    want.rdata = {hi_half, lo_half};
    if (lo_half[1:0] == 2'b11) begin
      return pc + 32'd4;
    end
    return pc + 32'd2;
  endfunction

  // Compressed instructions only own their low 16 bits
  task automatic check_instr(
    input align_pkg::fetch_resp_t got,
    input align_pkg::fetch_resp_t want,
    input logic [`ALIGN_XLEN-1:0] pc
  );
    logic ok;
    if (want.rdata[1:0] == 2'b11) begin
      ok = (got.rdata === want.rdata);
    end else begin
      ok = (got.rdata[15:0] === want.rdata[15:0]);
    end
    if (!ok || (got.err !== want.err)) begin
      $display("[ERROR] %0t: instruction at %h is %h err %b, expected %h err %b",
               $time, pc, got.rdata, got.err, want.rdata, want.err);
      stop_with_failure();
    end
  endtask

  task automatic check_addr(
    input logic [`ALIGN_XLEN-1:0] got,
    input logic [`ALIGN_XLEN-1:0] want,
    input string                  what
  );
    if (got !== want) begin
      $display("[ERROR] %0t: %s %h, expected %h", $time, what, got, want);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(
    input logic  got,
    input logic  want,
    input string what
  );
    if (got !== want) begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
      stop_with_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Drivers, prefetcher model and checker
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin : command_driver
    rst_n         <= rst_cmd;
    instr_req_i   <= req_cmd;
    branch_i      <= br_cmd;
    branch_addr_i <= br_addr_cmd;
  end

  // Samples on the falling edge and answers in order 1 to 3 cycles after acceptance
  always begin : prefetcher_model
    logic                   fire;
    logic                   got;
    logic                   br;
    logic [`ALIGN_XLEN-1:0] br_addr;
    logic [`ALIGN_XLEN-1:0] a;
    int                     due;
    align_pkg::fetch_resp_t r;
    @(negedge clk);
    if (rst_n) begin
      if (n_fire - n_resp > `ALIGN_MAX_OUTSTANDING) begin
        $display("[ERROR] %0t: %0d fetches in flight, limit %0d",
                 $time, n_fire - n_resp, `ALIGN_MAX_OUTSTANDING);
        stop_with_failure();
      end
      if ((n_fire != n_resp) && !prefetch_busy_o) begin
        $display("[ERROR] %0t: busy low with %0d fetches in flight", $time, n_fire - n_resp);
        stop_with_failure();
      end
      // Prefetcher restarts at the start of the word holding the target
      if (fetch_branch_o) begin
        check_addr(fetch_branch_addr_o, branch_addr_i & ~32'h3, "branch word address");
      end
    end
    fire    = rst_n && fetch_valid_o && fetch_ready_i;
    got     = resp_valid_i;
    br      = fetch_branch_o;
    br_addr = fetch_branch_addr_o;
    @(posedge clk);
    cycle  = cycle + 1;
    n_fire = n_fire + (fire ? 1 : 0);
    n_resp = n_resp + (got ? 1 : 0);
    if (fire) begin
      // A fetch in the branch cycle already targets the new word
      a   = br ? br_addr : pf_addr;
      due = cycle + int'($urandom % 3);
      if ((pend_due.size() != 0) && (due <= pend_due[$])) begin
        due = pend_due[$] + 1;
      end
      pend_addr.push_back(a);
      pend_due.push_back(due);
      pf_addr = a + 32'd4;
    end else if (br) begin
      pf_addr = br_addr;
    end
    if ((pend_due.size() != 0) && (pend_due[0] <= cycle)) begin
      a = pend_addr.pop_front();
      void'(pend_due.pop_front());
      r.rdata = mem[a[9:2]];
      r.err   = err_mem[a[9:2]];
      resp_valid_i <= 1'b1;
      resp_i       <= r;
    end else begin
      resp_valid_i <= 1'b0;
    end
    fetch_ready_i <= (($urandom % 4) != 0);
    instr_ready_i <= bp_on ? (($urandom % 2) == 0) : 1'b1;
  end

  always @(negedge clk) begin : emission_compare
    align_pkg::fetch_resp_t want;
    logic [`ALIGN_XLEN-1:0] nxt;
    if (rst_n) begin
      if (branch_i) begin
        check_flag(instr_valid_o, 1'b0, "instr_valid_o in a branch cycle");
        exp_pc = branch_addr_i;
      end else if (instr_valid_o && instr_ready_i) begin
        nxt = expect_instr(exp_pc, want);
        check_addr(instr_addr_o, exp_pc, "instruction address");
        check_instr(instr_o, want, exp_pc);
        exp_pc   = nxt;
        emit_cnt = emit_cnt + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Scenario helpers
  //////////////////////////////////////////////////////////////////////

  // Raises branch_i for one cycle when called just after a falling edge
  task automatic issue_branch(input logic [`ALIGN_XLEN-1:0] target, input logic backpressure);
    br_cmd      = 1'b1;
    br_addr_cmd = target;
    bp_on       = backpressure;
    @(negedge clk);
    br_cmd = 1'b0;
  endtask

  // Returns just after a falling edge
  task automatic wait_emissions(input int count);
    int target;
    int waited;
    @(posedge clk);
    target = emit_cnt + count;
    waited = 0;
    while (emit_cnt < target) begin
      if (waited == WAIT_LIMIT) begin
        $display("timeout waiting for %0d instructions", count);
        stop_with_failure();
      end
      @(posedge clk);
      waited = waited + 1;
    end
    @(negedge clk);
  endtask

  // Returns just after a falling edge once a fetch stays owed into the next cycle
  task automatic wait_outstanding();
    int waited;
    waited = 0;
    while ((n_fire - n_resp - (resp_valid_i ? 1 : 0)) < 1) begin
      if (waited == WAIT_LIMIT) begin
        $display("timeout waiting for a fetch to stay in flight");
        stop_with_failure();
      end
      @(negedge clk);
      waited = waited + 1;
    end
  endtask

  initial begin : scenarios
    int                     i;
    int                     k;
    int                     steps;
    logic                   found;
    logic [`ALIGN_XLEN-1:0] pc;
    logic [`ALIGN_XLEN-1:0] nxt;
    align_pkg::fetch_resp_t want;
    void'($urandom(32'h314a640b));
    // Words 0 to 63 hold only 32-bit instructions and the rest a mix
    for (i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = $urandom ^ (i * 32'h9e3779b9);
      err_mem[i] = 1'b0;
      if (i < 64) begin
        mem[i][1:0] = 2'b11;
      end else begin
        mem[i][1:0]   = start_bits();
        mem[i][17:16] = start_bits();
      end
    end
    repeat (2) @(negedge clk);
    rst_cmd = 1'b1;
    @(negedge clk);
    check_flag(fetch_valid_o, 1'b0, "fetch_valid_o after reset");
    check_flag(instr_valid_o, 1'b0, "instr_valid_o after reset");
    check_flag(prefetch_busy_o, 1'b0, "prefetch_busy_o after reset");
    req_cmd = 1'b1;
    // Aligned uncompressed stream
    issue_branch(32'h40, 1'b0);
    wait_emissions(20);
    // Mixed stream under back-pressure
    issue_branch(32'h100, 1'b1);
    wait_emissions(60);
    // Unaligned branch with fetches still owed
    wait_outstanding();
    issue_branch(32'h20a, 1'b1);
    wait_emissions(30);
    // Find a straddler and fault the word holding its second half
    pc    = 32'h320;
    steps = 0;
    found = 1'b0;
    for (k = 0; k < 64; k++) begin
      nxt = expect_instr(pc, want);
      if (!found && pc[1] && (want.rdata[1:0] == 2'b11)) begin
        found = 1'b1;
        steps = k;
        err_mem[pc[9:2] + 8'd1] = 1'b1;
      end
      pc = nxt;
    end
    if (!found) begin
      $display("no straddling instruction found for the bus error scenario");
      stop_with_failure();
    end
    issue_branch(32'h320, 1'b1);
    wait_emissions(steps + 8);
    $display("test passed");
    $finish;
  end

endmodule
